// File: logic/mips_pkg.sv
package mips_pkg;

	// primary opcode field, instr[31:26]
	typedef enum logic [5:0] {
		r_type  = 6'h00,
		op_j    = 6'h02,
		op_jal  = 6'h03,
		op_beq  = 6'h04,
		op_bne  = 6'h05,
		op_addi = 6'h08,
		op_andi = 6'h0c,
		op_ori  = 6'h0d,
		op_lw   = 6'h23,
		op_sw   = 6'h2b
	} opcode_t;

	// r-type funct field, instr[5:0]
	typedef enum logic [5:0] {
		f_sll = 6'h00,
		f_add = 6'h20,
		f_sub = 6'h22,
		f_and = 6'h24,
		f_or  = 6'h25,
		f_slt = 6'h2a
	} funct_t;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt,	// signed compare
		alu_sll	// b shifted by a[4:0]
	} alu_op_t;

	// one state per multicycle step
	typedef enum logic [3:0] {
		st_fetch,
		st_decode,
		st_memaddr,
		st_memrd,
		st_memwb,
		st_memwr,
		st_exec,
		st_aluwb,
		st_immex,
		st_immwb,
		st_branch,
		st_jump,
		st_jal
	} state_t;

	typedef enum logic [1:0] {srca_pc, srca_reg, srca_shamt} srca_t;
	typedef enum logic [1:0] {srcb_reg, srcb_four, srcb_imm, srcb_imm_sh} srcb_t;
	typedef enum logic [1:0] {pcsrc_alu, pcsrc_aluout, pcsrc_jump} pcsrc_t;
	typedef enum logic [1:0] {dst_rt, dst_rd, dst_r31} regdst_t;	// r31 takes pc as data

endpackage

// File: logic/ctrl_if.sv
interface ctrl_if;
	import mips_pkg::*;

	logic pc_write;	// unconditional pc load
	logic iord;	// memory address from alu_out
	logic mem_write;
	logic ir_write;
	logic reg_write;
	logic mem_to_reg;	// write back the data register
	logic zero_ext;	// andi / ori immediates
	logic branch_eq;
	logic branch_ne;
	srca_t alu_src_a;
	srcb_t alu_src_b;
	pcsrc_t pc_src;
	regdst_t reg_dst;
	alu_op_t alu_op;

	// control unit side
	modport ctrl (output pc_write, iord, mem_write, ir_write, reg_write, mem_to_reg,
		zero_ext, branch_eq, branch_ne, alu_src_a, alu_src_b, pc_src, reg_dst, alu_op);

	// datapath side
	modport dp (input pc_write, iord, mem_write, ir_write, reg_write, mem_to_reg,
		zero_ext, branch_eq, branch_ne, alu_src_a, alu_src_b, pc_src, reg_dst, alu_op);

endinterface

// File: logic/alu.sv
module alu (
	input logic [31:0] a,
	input logic [31:0] b,
	input mips_pkg::alu_op_t op,
	output logic [31:0] result,
	output logic zero
);
	import mips_pkg::*;

	logic [31:0] diff;

	assign diff = a - b;	// shared by sub and slt

	always_comb begin
		case (op)
			alu_add: result = a + b;
			alu_sub: result = diff;
			alu_and: result = a & b;
			alu_or: result = a | b;
			alu_slt: begin
				// signed compare, overflow aware
				if (a[31] != b[31])
					result = {31'b0, a[31]};
				else
					result = {31'b0, diff[31]};
			end
			alu_sll: result = b << a[4:0];
			default: result = a + b;
		endcase
	end

	assign zero = (result == 32'b0);

endmodule

// File: logic/register_file.sv
module register_file (
	input logic clk,
	input logic rstb,
	input logic [4:0] raddr1,
	input logic [4:0] raddr2,
	input logic [4:0] waddr,
	input logic [31:0] wdata,
	input logic we,
	output logic [31:0] rdata1,
	output logic [31:0] rdata2
);

	logic [31:0] regs [32];

	always_ff @(posedge clk) begin
		if (!rstb) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= 32'b0;
		end else if (we && waddr != 5'd0) begin	// r0 never written
			regs[waddr] <= wdata;
		end
	end

	// async read, r0 forced to zero
	assign rdata1 = (raddr1 == 5'd0) ? 32'b0 : regs[raddr1];
	assign rdata2 = (raddr2 == 5'd0) ? 32'b0 : regs[raddr2];

endmodule

// File: logic/control_unit.sv
module control_unit (
	input logic clk,
	input logic rstb,
	input logic [31:0] instr,	// latched instruction register
	ctrl_if.ctrl ctl
);
	import mips_pkg::*;

	state_t state, state_nxt;
	opcode_t opcode;
	funct_t funct;

	assign opcode = opcode_t'(instr[31:26]);
	assign funct = funct_t'(instr[5:0]);

	always_ff @(posedge clk) begin
		if (!rstb)
			state <= st_fetch;
		else
			state <= state_nxt;
	end

	// one step per cycle
	always_comb begin
		state_nxt = st_fetch;
		case (state)
			st_fetch: state_nxt = st_decode;
			st_decode: begin
				case (opcode)
					op_lw, op_sw: state_nxt = st_memaddr;
					r_type: state_nxt = st_exec;
					op_addi, op_andi, op_ori: state_nxt = st_immex;
					op_beq, op_bne: state_nxt = st_branch;
					op_j: state_nxt = st_jump;
					op_jal: state_nxt = st_jal;
					default: state_nxt = st_fetch;	// unsupported opcode skipped
				endcase
			end
			st_memaddr: state_nxt = (opcode == op_lw) ? st_memrd : st_memwr;
			st_memrd: state_nxt = st_memwb;
			st_exec: state_nxt = st_aluwb;
			st_immex: state_nxt = st_immwb;
			default: state_nxt = st_fetch;	// every chain ends back in fetch
		endcase
	end

	// control fields per state
	always_comb begin
		ctl.pc_write = 1'b0;
		ctl.iord = 1'b0;
		ctl.mem_write = 1'b0;
		ctl.ir_write = 1'b0;
		ctl.reg_write = 1'b0;
		ctl.mem_to_reg = 1'b0;
		ctl.zero_ext = 1'b0;
		ctl.branch_eq = 1'b0;
		ctl.branch_ne = 1'b0;
		ctl.alu_src_a = srca_pc;
		ctl.alu_src_b = srcb_reg;
		ctl.pc_src = pcsrc_alu;
		ctl.reg_dst = dst_rt;
		ctl.alu_op = alu_add;
		case (state)
			st_fetch: begin
				ctl.ir_write = 1'b1;
				ctl.pc_write = 1'b1;	// pc + 4 straight from the alu
				ctl.alu_src_b = srcb_four;
			end
			st_decode: ctl.alu_src_b = srcb_imm_sh;	// branch target into alu_out
			st_memaddr: begin
				ctl.alu_src_a = srca_reg;
				ctl.alu_src_b = srcb_imm;
			end
			st_memrd: ctl.iord = 1'b1;	// data register grabs the word
			st_memwr: begin
				ctl.iord = 1'b1;
				ctl.mem_write = 1'b1;
			end
			st_memwb: begin
				ctl.reg_write = 1'b1;
				ctl.mem_to_reg = 1'b1;
			end
			st_exec: begin
				ctl.alu_src_a = (funct == f_sll) ? srca_shamt : srca_reg;
				case (funct)
					f_sub: ctl.alu_op = alu_sub;
					f_and: ctl.alu_op = alu_and;
					f_or: ctl.alu_op = alu_or;
					f_slt: ctl.alu_op = alu_slt;
					f_sll: ctl.alu_op = alu_sll;
					default: ctl.alu_op = alu_add;
				endcase
			end
			st_aluwb: begin
				ctl.reg_write = 1'b1;
				ctl.reg_dst = dst_rd;
			end
			st_immex: begin
				ctl.alu_src_a = srca_reg;
				ctl.alu_src_b = srcb_imm;
				ctl.zero_ext = (opcode == op_andi) || (opcode == op_ori);
				if (opcode == op_andi)
					ctl.alu_op = alu_and;
				else if (opcode == op_ori)
					ctl.alu_op = alu_or;
			end
			st_immwb: ctl.reg_write = 1'b1;
			st_branch: begin
				ctl.alu_src_a = srca_reg;
				ctl.alu_op = alu_sub;	// zero flag compares a and b
				ctl.pc_src = pcsrc_aluout;
				ctl.branch_eq = (opcode == op_beq);
				ctl.branch_ne = (opcode == op_bne);
			end
			st_jump: begin
				ctl.pc_write = 1'b1;
				ctl.pc_src = pcsrc_jump;
			end
			st_jal: begin
				ctl.pc_write = 1'b1;
				ctl.pc_src = pcsrc_jump;
				ctl.reg_write = 1'b1;
				ctl.reg_dst = dst_r31;	// link value is the current pc
			end
			default: ;
		endcase
		if (!rstb) begin	// reset holds the load enables low
			ctl.pc_write = 1'b0;
			ctl.ir_write = 1'b0;
			ctl.mem_write = 1'b0;
			ctl.reg_write = 1'b0;
		end
	end

endmodule

// File: logic/mips.sv
module mips #(
	parameter logic [31:0] reset_addr = 32'h0000_0000
) (
	input logic clk,
	input logic rstb,
	input logic [31:0] mem_rd_data,	// instruction or load data
	output logic [31:0] mem_wr_data,
	output logic [31:0] mem_addr,
	output logic mem_wr_ena,
	output logic [31:0] pc
);
	import mips_pkg::*;

	ctrl_if ctl ();

	logic [31:0] instr;	// instruction register
	logic [31:0] data_reg;	// load data register
	logic [31:0] reg_a, reg_b;
	logic [31:0] alu_out;

	logic [31:0] src_a, src_b;
	logic [31:0] alu_result;
	logic alu_zero;
	logic [31:0] ext_imm;
	logic [31:0] rd1, rd2;
	logic [4:0] waddr;
	logic [31:0] wdata;
	logic pc_en;
	logic [31:0] pc_nxt;

	control_unit u_control (
		.clk(clk),
		.rstb(rstb),
		.instr(instr),
		.ctl(ctl)
	);

	// immediate, sign or zero extended
	assign ext_imm = ctl.zero_ext ? {16'b0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

	always_comb begin
		case (ctl.alu_src_a)
			srca_pc: src_a = pc;
			srca_reg: src_a = reg_a;
			srca_shamt: src_a = {27'b0, instr[10:6]};	// sll amount
			default: src_a = pc;
		endcase
		case (ctl.alu_src_b)
			srcb_reg: src_b = reg_b;
			srcb_four: src_b = 32'd4;
			srcb_imm: src_b = ext_imm;
			srcb_imm_sh: src_b = {ext_imm[29:0], 2'b00};	// word offset to bytes
			default: src_b = reg_b;
		endcase
	end

	alu u_alu (
		.a(src_a),
		.b(src_b),
		.op(ctl.alu_op),
		.result(alu_result),
		.zero(alu_zero)
	);

	// write port steering
	always_comb begin
		wdata = ctl.mem_to_reg ? data_reg : alu_out;
		case (ctl.reg_dst)
			dst_rt: waddr = instr[20:16];
			dst_rd: waddr = instr[15:11];
			dst_r31: begin
				waddr = 5'd31;
				wdata = pc;	// already jal + 4
			end
			default: waddr = instr[20:16];
		endcase
	end

	register_file u_regs (
		.clk(clk),
		.rstb(rstb),
		.raddr1(instr[25:21]),	// rs
		.raddr2(instr[20:16]),	// rt
		.waddr(waddr),
		.wdata(wdata),
		.we(ctl.reg_write),
		.rdata1(rd1),
		.rdata2(rd2)
	);

	// branch decision lives here only
	assign pc_en = ctl.pc_write || (ctl.branch_eq && alu_zero) || (ctl.branch_ne && !alu_zero);

	always_comb begin
		case (ctl.pc_src)
			pcsrc_alu: pc_nxt = alu_result;
			pcsrc_aluout: pc_nxt = alu_out;	// target from decode
			pcsrc_jump: pc_nxt = {pc[31:28], instr[25:0], 2'b00};
			default: pc_nxt = alu_result;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstb) begin
			pc <= reset_addr;
			instr <= 32'b0;
			data_reg <= 32'b0;
			reg_a <= 32'b0;
			reg_b <= 32'b0;
			alu_out <= 32'b0;
		end else begin
			// operand and result registers load every cycle
			reg_a <= rd1;
			reg_b <= rd2;
			alu_out <= alu_result;
			data_reg <= mem_rd_data;	// only meaningful after memrd
			if (ctl.ir_write)
				instr <= mem_rd_data;
			if (pc_en)
				pc <= pc_nxt;
		end
	end

	// memory port
	assign mem_addr = ctl.iord ? alu_out : pc;
	assign mem_wr_data = reg_b;	// sw data is rt
	assign mem_wr_ena = ctl.mem_write;

endmodule

// File: verif/tb_mem.sv
module tb_mem (
	input logic clk,
	input logic rstb,
	input logic [31:0] addr,
	input logic [31:0] wr_data,
	input logic wr_ena,
	output logic [31:0] rd_data
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [31:0] words [1024];	// 4 KB, word addressed
	logic [31:0] log_addr [64];	// store log, cleared by reset
	logic [31:0] log_data [64];
	int log_cnt;

	assign rd_data = words[addr[11:2]];	// combinational read

	always @(posedge clk) begin
		if (!rstb) begin
			log_cnt <= 0;
		end else if (wr_ena) begin
			words[addr[11:2]] = wr_data;
			log_addr[log_cnt] <= addr;
			log_data[log_cnt] <= wr_data;
			log_cnt <= log_cnt + 1;
		end
	end

endmodule

// File: verif/tb_mips.sv
module tb_mips;
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] reset_addr = 32'h0000_0040;
	localparam int budget = 400;	// cycles per wait
	localparam int lat_lw = 5;
	localparam int lat_branch = 3;
	localparam int lat_jump = 3;
	localparam int lat_sw = 4;
	localparam int watchdog_ns = 6 * (budget + 40) * 40 + 4000;
	// isa encodings
	localparam logic [5:0] opc_j = 6'h02, opc_jal = 6'h03, opc_beq = 6'h04, opc_bne = 6'h05;
	localparam logic [5:0] opc_addi = 6'h08, opc_andi = 6'h0c, opc_ori = 6'h0d;
	localparam logic [5:0] opc_lw = 6'h23, opc_sw = 6'h2b;
	localparam logic [5:0] fn_sll = 6'h00, fn_add = 6'h20, fn_sub = 6'h22;
	localparam logic [5:0] fn_and = 6'h24, fn_or = 6'h25, fn_slt = 6'h2a;

	logic clk, rstb;
	logic [31:0] mem_rd_data, mem_wr_data, mem_addr, pc;
	logic mem_wr_ena;
	integer seed = 95181;
	logic [31:0] prog [$];
	logic [31:0] preset_addr [$], preset_data [$];
	logic [31:0] exp_addr [$], exp_data [$];
	int test_errs, n_pass, n_fail, run_cycles;

	mips #(.reset_addr(reset_addr)) uut (.clk(clk), .rstb(rstb), .mem_rd_data(mem_rd_data),
		.mem_wr_data(mem_wr_data), .mem_addr(mem_addr), .mem_wr_ena(mem_wr_ena), .pc(pc));

	tb_mem u_mem (.clk(clk), .rstb(rstb), .addr(mem_addr), .wr_data(mem_wr_data),
		.wr_ena(mem_wr_ena), .rd_data(mem_rd_data));

	always #20 clk = ~clk;

	initial begin	// watchdog
		#(watchdog_ns);
		$display("run timed out at %0t, a test never finished", $time);
		$display("Simulation finished: FAIL");
		$finish;
	end

	function automatic logic [31:0] enc_r(logic [5:0] fn, int rs, int rt, int rd, int sh);
		return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
	endfunction

	function automatic logic [31:0] enc_i(logic [5:0] op, int rs, int rt, logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic logic [31:0] enc_j(logic [5:0] op, logic [31:0] target);
		return {op, target[27:2]};
	endfunction

	function automatic logic [31:0] here();	// address of the next emitted word
		return reset_addr + 32'(4 * prog.size());
	endfunction

	task automatic new_test();
		prog.delete();
		preset_addr.delete();
		preset_data.delete();
		exp_addr.delete();
		exp_data.delete();
		test_errs = 0;
	endtask

	task automatic emit_store(int rt, logic [15:0] off, logic [31:0] value);
		prog.push_back(enc_i(opc_sw, 0, rt, off));	// r0 base so the offset is the address
		exp_addr.push_back({16'h0, off});
		exp_data.push_back(value);
	endtask

	task automatic hold_reset_and_load();
		@(posedge clk);
		rstb <= 1'b0;
		repeat (3) @(posedge clk);
		for (int i = 0; i < 1024; i++)
			u_mem.words[i] = 32'hfc00_0000 | 32'(i);	// opcode 3f is skipped by the core
		for (int i = 0; i < preset_addr.size(); i++)
			u_mem.words[preset_addr[i][11:2]] = preset_data[i];
		for (int i = 0; i < prog.size(); i++)
			u_mem.words[reset_addr[11:2] + 10'(i)] = prog[i];
	endtask

	task automatic release_reset();
		@(posedge clk);
		rstb <= 1'b1;
		run_cycles = 0;	// first edge after this one is fetch
	endtask

	task automatic wait_stores(int n);
		while (u_mem.log_cnt < n && run_cycles < budget) begin
			@(posedge clk);
			run_cycles++;
			@(negedge clk);
		end
		if (u_mem.log_cnt < n) begin
			$display("only %0d of %0d stores seen within %0d cycles", u_mem.log_cnt, n, budget);
			test_errs++;
		end
	endtask

	task automatic settle_and_check();	// extra cycles catch stray stores
		repeat (20) @(posedge clk);
		@(negedge clk);
		if (u_mem.log_cnt != exp_addr.size()) begin
			$display("ERR %0t: %0d stores logged, expected %0d", $time, u_mem.log_cnt,
				exp_addr.size());
			test_errs++;
		end
		for (int i = 0; i < exp_addr.size() && i < u_mem.log_cnt; i++) begin
			if (u_mem.log_addr[i] !== exp_addr[i] || u_mem.log_data[i] !== exp_data[i]
					|| u_mem.words[exp_addr[i][11:2]] !== exp_data[i]) begin
				$display("ERR %0t: store %0d wrote %h at %h, expected %h at %h", $time, i,
					u_mem.log_data[i], u_mem.log_addr[i], exp_data[i], exp_addr[i]);
				test_errs++;
			end
		end
	endtask

	task automatic report_test(string name);
		if (test_errs == 0) begin
			n_pass++;
			$display("%-10s ok", name);
		end else begin
			n_fail++;
			$display("%-10s failed, %0d errors", name, test_errs);
		end
	endtask

	task automatic test_reset_state();
		new_test();
		prog.push_back(enc_j(opc_j, here()));	// spin in place
		hold_reset_and_load();
		@(negedge clk);
		if (pc !== reset_addr || mem_wr_ena !== 1'b0) begin
			$display("ERR %0t: in reset pc %h wr_ena %b", $time, pc, mem_wr_ena);
			test_errs++;
		end
		release_reset();
		@(posedge clk);
		@(negedge clk);
		if (pc !== reset_addr + 32'd4 || mem_wr_ena !== 1'b0) begin
			$display("ERR %0t: after fetch pc %h, expected %h", $time, pc, reset_addr + 4);
			test_errs++;
		end
		report_test("reset");
	endtask

	task automatic test_arith();
		logic [15:0] imm1, imm2, imm3;
		logic [4:0] sh;
		logic [31:0] a, b;
		new_test();
		imm1 = 16'($random(seed)) | 16'h8000;	// negative so sign extension matters
		imm2 = 16'($random(seed)) & 16'h7fff;	// positive
		imm3 = 16'($random(seed)) | 16'h8000;	// top bit set so the extension kind shows
		sh = 5'($random(seed)) | 5'h01;	// nonzero shift
		a = {{16{imm1[15]}}, imm1};	// addi sign extends
		b = {{16{imm2[15]}}, imm2};
		prog.push_back(enc_i(opc_addi, 0, 1, imm1));
		prog.push_back(enc_i(opc_addi, 0, 2, imm2));
		prog.push_back(enc_r(fn_add, 1, 2, 3, 0));
		emit_store(3, 16'h0800, a + b);
		prog.push_back(enc_r(fn_sub, 1, 2, 4, 0));
		emit_store(4, 16'h0804, a - b);
		prog.push_back(enc_r(fn_and, 1, 2, 5, 0));
		emit_store(5, 16'h0808, a & b);
		prog.push_back(enc_r(fn_or, 1, 2, 6, 0));
		emit_store(6, 16'h080c, a | b);
		prog.push_back(enc_r(fn_slt, 1, 2, 7, 0));
		emit_store(7, 16'h0810, 32'($signed(a) < $signed(b)));
		prog.push_back(enc_r(fn_slt, 2, 1, 8, 0));
		emit_store(8, 16'h0814, 32'($signed(b) < $signed(a)));
		prog.push_back(enc_r(fn_sll, 0, 2, 9, sh));
		emit_store(9, 16'h0818, b << sh);
		prog.push_back(enc_i(opc_andi, 1, 10, imm3));
		emit_store(10, 16'h081c, a & {16'h0, imm3});	// logical immediates zero extend
		prog.push_back(enc_i(opc_ori, 2, 11, imm3));
		emit_store(11, 16'h0820, b | {16'h0, imm3});
		prog.push_back(enc_i(opc_addi, 1, 0, imm3));	// both writes to r0 are dropped
		prog.push_back(enc_r(fn_add, 1, 2, 0, 0));
		emit_store(0, 16'h0824, 32'h0);
		emit_store(1, 16'h0828, a);
		prog.push_back(enc_j(opc_j, here()));
		hold_reset_and_load();
		release_reset();
		wait_stores(exp_addr.size());
		settle_and_check();
		report_test("arith");
	endtask

	task automatic test_load_store();
		logic [31:0] w [3];
		new_test();
		for (int i = 0; i < 3; i++) begin
			w[i] = $random(seed);
			preset_addr.push_back(32'h0900 + 32'(4 * i));
			preset_data.push_back(w[i]);
		end
		prog.push_back(enc_i(opc_lw, 0, 1, 16'h0900));
		prog.push_back(enc_i(opc_lw, 0, 2, 16'h0904));
		prog.push_back(enc_i(opc_addi, 0, 6, 16'h0900));	// base register
		prog.push_back(enc_i(opc_lw, 6, 3, 16'h0008));
		prog.push_back(enc_r(fn_add, 1, 2, 4, 0));
		emit_store(4, 16'h0a00, w[0] + w[1]);
		prog.push_back(enc_r(fn_add, 4, 3, 5, 0));
		emit_store(5, 16'h0a04, w[0] + w[1] + w[2]);
		prog.push_back(enc_i(opc_sw, 6, 3, 16'h010c));	// 0x900 + 0x10c
		exp_addr.push_back(32'h0a0c);
		exp_data.push_back(w[2]);
		prog.push_back(enc_j(opc_j, here()));
		hold_reset_and_load();
		release_reset();
		wait_stores(exp_addr.size());
		settle_and_check();
		report_test("load_store");
	endtask

	task automatic test_branches();
		logic [31:0] vals [4] = '{32'd0, 32'd7, 32'd7, 32'd9};	// r0..r3
		logic [5:0] bop [4] = '{opc_beq, opc_beq, opc_bne, opc_bne};
		int brt [4] = '{2, 3, 3, 2};	// rs is always r1
		logic taken;
		new_test();
		for (int r = 1; r < 4; r++)
			prog.push_back(enc_i(opc_addi, 0, r, vals[r][15:0]));
		for (int k = 0; k < 4; k++) begin
			prog.push_back(enc_i(opc_addi, 0, 10 + k, 16'(16'h0100 + k)));	// skip markers
			prog.push_back(enc_i(opc_addi, 0, 20 + k, 16'(16'h0200 + k)));
		end
		for (int k = 0; k < 4; k++) begin
			taken = (bop[k] == opc_beq) ? (vals[1] == vals[brt[k]]) : (vals[1] != vals[brt[k]]);
			prog.push_back(enc_i(bop[k], 1, brt[k], 16'h0001));	// over one store
			prog.push_back(enc_i(opc_sw, 0, 10 + k, 16'(16'h0800 + 8 * k)));
			if (!taken) begin
				exp_addr.push_back(32'h0800 + 32'(8 * k));
				exp_data.push_back(32'h0100 + 32'(k));
			end
			emit_store(20 + k, 16'(16'h0804 + 8 * k), 32'h0200 + 32'(k));
		end
		prog.push_back(enc_j(opc_j, here()));
		hold_reset_and_load();
		release_reset();
		wait_stores(exp_addr.size());
		settle_and_check();
		report_test("branches");
	endtask

	task automatic test_jumps();
		logic [31:0] jal_addr, target;
		new_test();
		prog.push_back(enc_i(opc_addi, 0, 1, 16'h005a));
		prog.push_back(enc_j(opc_j, here() + 8));
		prog.push_back(enc_i(opc_sw, 0, 1, 16'h0800));	// jumped over
		emit_store(1, 16'h0804, 32'h005a);
		jal_addr = here();
		target = jal_addr + 8;
		prog.push_back(enc_j(opc_jal, target));
		prog.push_back(enc_i(opc_sw, 0, 1, 16'h0808));	// no return path
		emit_store(31, 16'h080c, jal_addr + 4);
		prog.push_back(enc_j(opc_j, here()));
		hold_reset_and_load();
		release_reset();
		wait_stores(1);
		repeat (lat_jump) @(posedge clk);	// fetch, decode, jal
		@(negedge clk);
		if (pc !== target) begin
			$display("ERR %0t: pc after jal %h, expected %h", $time, pc, target);
			test_errs++;
		end
		wait_stores(2);
		settle_and_check();
		report_test("jumps");
	endtask

	task automatic test_cycles();
		logic [31:0] w;
		new_test();
		w = $random(seed) | 32'h1;	// nonzero so beq falls through
		preset_addr.push_back(32'h0900);
		preset_data.push_back(w);
		prog.push_back(enc_i(opc_lw, 0, 1, 16'h0900));
		prog.push_back(enc_i(opc_beq, 1, 0, 16'h0001));
		emit_store(1, 16'h0904, w);
		prog.push_back(enc_j(opc_j, here()));
		hold_reset_and_load();
		release_reset();
		wait_stores(1);
		if (run_cycles != lat_lw + lat_branch + lat_sw) begin
			$display("ERR %0t: store at cycle %0d, expected %0d", $time, run_cycles,
				lat_lw + lat_branch + lat_sw);
			test_errs++;
		end
		settle_and_check();
		report_test("cycles");
	endtask

	initial begin
		clk = 1'b0;
		rstb = 1'b0;
		n_pass = 0;
		n_fail = 0;
		test_reset_state();
		test_arith();
		test_load_store();
		test_branches();
		test_jumps();
		test_cycles();
		$display("tests passed: %0d, failed: %0d", n_pass, n_fail);
		if (n_fail == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// File: verilog.f
logic/mips_pkg.sv
logic/ctrl_if.sv
logic/alu.sv
logic/register_file.sv
logic/control_unit.sv
logic/mips.sv
verif/tb_mem.sv
verif/tb_mips.sv

// File: Makefile
TOP = tb_mips

sim:
	verilator --binary --timing -f verilog.f --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
